/* design/fp24_pkg.sv */
// Number format of the 24-bit floating-point type with field layout and widths
package fp24_pkg;

  // Exponent field width, bias 63
  localparam int exp_w = 7;

  // Stored mantissa width, hidden one not included
  localparam int mant_w = 16;

  // Fraction with hidden one plus one carry bit on top
  localparam int frac_w = mant_w + 2;

  // Field layout, sign in the top bit
  // An exponent of zero encodes the value zero and the mantissa is ignored
  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [mant_w-1:0] mant;
  } fp24_t;

endpackage

/* design/fp24_pipe_pkg.sv */
// Pipeline payloads of the fp24 adder for the request and each stage link
package fp24_pipe_pkg;

  import fp24_pkg::*;

  // One add or subtract request
  typedef struct packed {
    fp24_t a;
    fp24_t b;
    logic  is_sub;
  } add_req_t;

  // Align to add/subtract
  // Operands already ordered, frac_small already shifted
  typedef struct packed {
    logic              sign_big;
    logic              eff_sub;
    logic [exp_w-1:0]  exp_big;
    logic [frac_w-1:0] frac_big;
    logic [frac_w-1:0] frac_small;
  } aligned_t;

  // Add/subtract to normalize
  // Top bit of frac_sum is the carry out of the addition
  typedef struct packed {
    logic              sign;
    logic [exp_w-1:0]  exp;
    logic [frac_w-1:0] frac_sum;
  } sum_t;

endpackage

/* design/fp24_clz.sv */
// Leading-zero counter of any width, searching from the top bit down
module fp24_clz #(
  parameter int width = 17
) (
  input  logic [width-1:0]             x,
  output logic [$clog2(width+1)-1:0]   count
);

  localparam int cnt_w = $clog2(width + 1);

  logic found;

  always_comb begin
    found = 1'b0;
    // All-zero input falls through to width
    count = cnt_w'(width);
    for (int i = width - 1; i >= 0; i--) begin
      if (!found && x[i]) begin
        found = 1'b1;
        count = cnt_w'(width - 1 - i);
      end
    end
  end

endmodule

/* design/fp24_align.sv */
// Align stage of the fp24 adder that orders the operands and shifts the smaller fraction
module fp24_align (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  fp24_pipe_pkg::add_req_t in_req,
  output logic                    out_valid,
  input  logic                    out_ready,
  output fp24_pipe_pkg::aligned_t out_data
);

  import fp24_pkg::*;
  import fp24_pipe_pkg::*;

  logic              sign_b_eff;
  logic [frac_w-1:0] frac_a;
  logic [frac_w-1:0] frac_b;
  logic              a_bigger;
  logic [exp_w-1:0]  exp_small;
  logic [exp_w-1:0]  exp_diff;
  logic [frac_w-1:0] frac_small_raw;
  aligned_t          next_data;

  // Subtraction is addition with b negated
  assign sign_b_eff = in_req.b.sign ^ in_req.is_sub;

  // Zero exponent gives a zero fraction, mantissa ignored
  assign frac_a = (in_req.a.exp != '0) ? {2'b01, in_req.a.mant} : '0;
  assign frac_b = (in_req.b.exp != '0) ? {2'b01, in_req.b.mant} : '0;

  // Magnitude compare, exponent first
  assign a_bigger = (in_req.a.exp > in_req.b.exp) ||
                    ((in_req.a.exp == in_req.b.exp) && (in_req.a.mant >= in_req.b.mant));

  always_comb begin
    next_data.sign_big = a_bigger ? in_req.a.sign : sign_b_eff;
    next_data.exp_big  = a_bigger ? in_req.a.exp : in_req.b.exp;
    next_data.frac_big = a_bigger ? frac_a : frac_b;
    exp_small          = a_bigger ? in_req.b.exp : in_req.a.exp;
    frac_small_raw     = a_bigger ? frac_b : frac_a;
    next_data.eff_sub  = in_req.a.sign ^ sign_b_eff;

    // Never negative after the swap
    exp_diff = next_data.exp_big - exp_small;

    // Everything shifted out for a large difference
    if (exp_diff >= exp_w'(frac_w)) begin
      next_data.frac_small = '0;
    end else begin
      next_data.frac_small = frac_small_raw >> exp_diff;
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= next_data;
    end
  end

  // Stalled item must not change before the next stage takes it
  a_hold_stable: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

/* design/fp24_addsub.sv */
// Add/subtract stage of the fp24 adder that combines the aligned fractions
module fp24_addsub (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  fp24_pipe_pkg::aligned_t in_data,
  output logic                    out_valid,
  input  logic                    out_ready,
  output fp24_pipe_pkg::sum_t     out_data
);

  import fp24_pkg::*;
  import fp24_pipe_pkg::*;

  logic [frac_w-1:0] frac_sum;

  // Carry lands in the top bit, reserved for it in frac_w
  always_comb begin
    if (in_data.eff_sub) begin
      frac_sum = in_data.frac_big - in_data.frac_small;
    end else begin
      frac_sum = in_data.frac_big + in_data.frac_small;
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // Sign and exponent come from the larger operand
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data.sign     <= in_data.sign_big;
      out_data.exp      <= in_data.exp_big;
      out_data.frac_sum <= frac_sum;
    end
  end

  // Ordering done in the align stage keeps the difference non-negative
  a_no_negative: assert property (
    @(posedge clk) disable iff (!arst_n)
    in_valid && in_ready && in_data.eff_sub |-> in_data.frac_big >= in_data.frac_small
  );

endmodule

/* design/fp24_normalize.sv */
// Normalize stage of the fp24 adder that shifts the sum and packs the result
module fp24_normalize (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  fp24_pipe_pkg::sum_t in_data,
  output logic                out_valid,
  input  logic                out_ready,
  output fp24_pkg::fp24_t     out_sum
);

  import fp24_pkg::*;
  import fp24_pipe_pkg::*;

  // Hidden one plus stored mantissa, carry bit excluded
  localparam int norm_w = mant_w + 1;
  localparam int lz_w   = $clog2(norm_w + 1);

  logic [lz_w-1:0]   lz;
  logic [norm_w-1:0] frac_norm;
  logic [exp_w-1:0]  exp_norm;
  fp24_t             result;

  fp24_clz #(
    .width(norm_w)
  ) clz_i (
    .x    (in_data.frac_sum[norm_w-1:0]),
    .count(lz)
  );

  always_comb begin
    if (in_data.frac_sum[frac_w-1]) begin
      // Carry out, one step right, low bit dropped
      frac_norm = in_data.frac_sum[frac_w-1:1];
      exp_norm  = in_data.exp + 1'b1;
    end else begin
      // Cancellation moves the leading one down
      frac_norm = in_data.frac_sum[norm_w-1:0] << lz;
      exp_norm  = in_data.exp - exp_w'(lz);
    end

    if (in_data.frac_sum == '0) begin
      // Exact cancellation, always +0
      result = '0;
    end else begin
      result.sign = in_data.sign;
      result.exp  = exp_norm;
      result.mant = frac_norm[mant_w-1:0];
    end
  end

  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_sum <= result;
    end
  end

  a_idle_in_reset: assert property (
    @(posedge clk) !arst_n |-> !out_valid
  );

endmodule

/* design/fp24_add_top.sv */
// Top level of the three-stage fp24 adder and subtractor
module fp24_add_top (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  output logic                    in_ready,
  input  fp24_pipe_pkg::add_req_t in_req,
  output logic                    out_valid,
  input  logic                    out_ready,
  output fp24_pkg::fp24_t         out_sum
);

  import fp24_pipe_pkg::*;

  // Align to add/subtract
  logic     s1_valid;
  logic     s1_ready;
  aligned_t s1_data;

  // Add/subtract to normalize
  logic     s2_valid;
  logic     s2_ready;
  sum_t     s2_data;

  fp24_align align_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_req   (in_req),
    .out_valid(s1_valid),
    .out_ready(s1_ready),
    .out_data (s1_data)
  );

  fp24_addsub addsub_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (s1_valid),
    .in_ready (s1_ready),
    .in_data  (s1_data),
    .out_valid(s2_valid),
    .out_ready(s2_ready),
    .out_data (s2_data)
  );

  fp24_normalize normalize_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (s2_valid),
    .in_ready (s2_ready),
    .in_data  (s2_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_sum  (out_sum)
  );

endmodule

/* test/clock_gen.sv */
// Clock and reset source for the fp24 adder testbench
module clock_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Release away from the rising edge
  initial begin
    arst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

/* test/fp24_add_tb.sv */
// Testbench for the fp24 adder with a directed table, random cases and back-pressure
module fp24_add_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import fp24_pkg::*;
  import fp24_pipe_pkg::*;

  typedef struct packed {
    fp24_t a;
    fp24_t b;
    logic  is_sub;
    fp24_t sum;
  } table_row_t;

  localparam int n_table        = 14;
  localparam int n_rand         = 40;
  localparam int n_stall        = 6;
  localparam int timeout_cycles = 10 * (n_table + n_rand + n_stall) + 50;
  localparam int hidden_one     = 1 << 16;
  localparam int carry_bit      = 1 << 17;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  logic     in_ready;
  add_req_t in_req;
  logic     out_valid;
  logic     out_ready;
  fp24_t    out_sum;

  logic [31:0] lfsr;
  logic [23:0] want_q[$];
  string       name_q[$];
  int          pass_cnt;
  int          fail_cnt;
  int          sent_cnt;
  int          seen_cnt;
  int          cycles;

  // Expected sums worked out by hand
  table_row_t table_v [n_table] = '{
    '{24'h3F8000, 24'h3F8000, 1'b0, 24'h408000},
    '{24'h3F8001, 24'h3F8000, 1'b0, 24'h408000},
    '{24'h3F0000, 24'h3D0003, 1'b0, 24'h3F4000},
    '{24'h3F0000, 24'h3E8000, 1'b1, 24'h3D0000},
    '{24'h3E8000, 24'h3F0000, 1'b1, 24'hBD0000},
    '{24'h3F0000, 24'hBF0000, 1'b1, 24'h400000},
    '{24'h3F8000, 24'h3F8000, 1'b1, 24'h000000},
    '{24'hBF8000, 24'hBF8000, 1'b1, 24'h000000},
    '{24'h000000, 24'h000000, 1'b1, 24'h000000},
    '{24'h800000, 24'h000000, 1'b1, 24'h000000},
    '{24'h3F8000, 24'h000000, 1'b0, 24'h3F8000},
    '{24'h000000, 24'hC12345, 1'b0, 24'hC12345},
    '{24'h00ABCD, 24'h058000, 1'b0, 24'h058000},
    '{24'h641234, 24'h145678, 1'b1, 24'h641234}
  };

  string table_name [n_table] = '{
    "carry_1p5_plus_1p5", "carry_trunc", "align_trunc", "cancel_partial",
    "sign_from_larger", "sub_neg_b", "cancel_exact", "cancel_exact_neg",
    "zero_minus_zero", "negzero_minus_zero", "x_plus_zero", "zero_plus_x",
    "zero_mant_ignored", "far_exponents"
  };

  clock_gen clock_gen_i (
    .clk   (clk),
    .arst_n(arst_n)
  );

  fp24_add_top dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_req   (in_req),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_sum  (out_sum)
  );

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic fp24_t random_operand();
    fp24_t v;
    v.sign = 1'(take_bits(1));
    v.exp  = 7'(20 + take_bits(7) % 81);
    v.mant = 16'(take_bits(16));
    return v;
  endfunction

  function automatic add_req_t random_req();
    add_req_t r;
    r.a      = random_operand();
    r.b      = random_operand();
    r.is_sub = 1'(take_bits(1));
    return r;
  endfunction

  // Truncating add of sign-magnitude values in integer arithmetic
  function automatic logic [23:0] ref_sum(input add_req_t req);
    logic s_a;
    logic s_b;
    logic s_hi;
    int   e_a;
    int   e_b;
    int   e_hi;
    int   e_lo;
    int   f_a;
    int   f_b;
    int   f_hi;
    int   f_lo;
    int   f;
    s_a = req.a.sign;
    s_b = req.b.sign ^ req.is_sub;
    e_a = int'(req.a.exp);
    e_b = int'(req.b.exp);
    f_a = (e_a == 0) ? 0 : hidden_one + int'(req.a.mant);
    f_b = (e_b == 0) ? 0 : hidden_one + int'(req.b.mant);
    if (e_a > e_b || (e_a == e_b && f_a >= f_b)) begin
      s_hi = s_a;
      e_hi = e_a;
      f_hi = f_a;
      e_lo = e_b;
      f_lo = f_b;
    end else begin
      s_hi = s_b;
      e_hi = e_b;
      f_hi = f_b;
      e_lo = e_a;
      f_lo = f_a;
    end
    f_lo = (e_hi - e_lo > 20) ? 0 : f_lo >> (e_hi - e_lo);
    f = (s_a != s_b) ? f_hi - f_lo : f_hi + f_lo;
    if (f == 0) begin
      return 24'h000000;
    end
    if (f >= carry_bit) begin
      f = f >> 1;
      e_hi++;
    end
    while (f < hidden_one) begin
      f = f << 1;
      e_hi--;
    end
    return {s_hi, 7'(e_hi), f[15:0]};
  endfunction

  task automatic expect_result(input logic [23:0] want, input string name);
    want_q.push_back(want);
    name_q.push_back(name);
    sent_cnt++;
  endtask

  // Inputs already driven, wait for a cycle where in_ready is high
  task automatic wait_accept(input logic [23:0] want, input string name);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      #1;
      taken = in_ready;
      if (!taken) begin
        @(negedge clk);
      end
    end
    expect_result(want, name);
  endtask

  task automatic send_request(input add_req_t req, input logic [23:0] want,
                              input string name);
    @(negedge clk);
    in_valid = 1'b1;
    in_req   = req;
    wait_accept(want, name);
  endtask

  task automatic stop_input();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (want_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic check_output(input logic [23:0] got);
    logic [23:0] want;
    string       name;
    if (want_q.size() == 0) begin
      $display("ERROR: output %h arrived with no request pending", got);
      fail_cnt++;
    end else begin
      want = want_q.pop_front();
      name = name_q.pop_front();
      seen_cnt++;
      if (got !== want) begin
        $display("MISMATCH %s expected %h actual %h", name, want, got);
        fail_cnt++;
      end else begin
        $display("ok %s %h", name, got);
        pass_cnt++;
      end
    end
  endtask

  // Output held for 8 cycles while the input side keeps offering
  task automatic stall_test();
    add_req_t req;
    int       accepted;
    accepted = 0;
    req = random_req();
    @(negedge clk);
    out_ready = 1'b0;
    for (int c = 0; c < 8; c++) begin
      if (c != 0) begin
        @(negedge clk);
      end
      in_valid = 1'b1;
      in_req   = req;
      #1;
      if (in_ready) begin
        expect_result(ref_sum(req), $sformatf("stall_%0d", accepted));
        accepted++;
        req = random_req();
      end
    end
    if (accepted != 3 || in_ready) begin
      $display("ERROR: in_ready did not fall after three accepted inputs (%0d accepted)",
               accepted);
      fail_cnt++;
    end else begin
      $display("ok stall_in_ready");
      pass_cnt++;
    end
    // Pending item goes in on the first edge after release
    @(negedge clk);
    out_ready = 1'b1;
    wait_accept(ref_sum(req), $sformatf("stall_%0d", accepted));
    for (int k = accepted + 1; k < n_stall; k++) begin
      req = random_req();
      send_request(req, ref_sum(req), $sformatf("stall_%0d", k));
    end
  endtask

  always @(posedge clk) begin
    if (arst_n && out_valid && out_ready) begin
      check_output(out_sum);
    end
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d results missing", cycles, want_q.size());
    $display("Test failures found");
    $finish;
  end

  initial begin
    add_req_t req;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b1;
    lfsr      = 32'hccd881e8;
    pass_cnt  = 0;
    fail_cnt  = 0;
    sent_cnt  = 0;
    seen_cnt  = 0;

    @(posedge arst_n);
    @(negedge clk);
    #1;
    if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
      $display("ERROR: after reset out_valid is %b and in_ready is %b", out_valid, in_ready);
      fail_cnt++;
    end else begin
      $display("ok reset_state");
      pass_cnt++;
    end

    for (int i = 0; i < n_table; i++) begin
      req.a      = table_v[i].a;
      req.b      = table_v[i].b;
      req.is_sub = table_v[i].is_sub;
      send_request(req, table_v[i].sum, table_name[i]);
    end

    for (int i = 0; i < n_rand; i++) begin
      req = random_req();
      send_request(req, ref_sum(req), $sformatf("rand_%0d", i));
    end
    stop_input();
    wait_drain();

    stall_test();
    stop_input();
    wait_drain();

    if (seen_cnt != sent_cnt) begin
      $display("ERROR: %0d requests sent but %0d results received", sent_cnt, seen_cnt);
      fail_cnt++;
    end
    $display("Done: %0d passed, %0d failed, %0d of %0d results received",
             pass_cnt, fail_cnt, seen_cnt, sent_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* project.f */
design/fp24_pkg.sv
design/fp24_pipe_pkg.sv
design/fp24_clz.sv
design/fp24_align.sv
design/fp24_addsub.sv
design/fp24_normalize.sv
design/fp24_add_top.sv
test/clock_gen.sv
test/fp24_add_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fp24_add_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failures found" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then \
	  echo "Simulation FAILED"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
